/* rtl/spectrum_pkg.sv */
package spectrum_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // Data widths
    ////////////////////////////////////////////////////////////////////////////

    // One FFT bin magnitude
    localparam int SAMPLE_WIDTH = 16;

    // Squared sample plus growth for up to 1024 bins
    localparam int ENERGY_WIDTH = 2 * SAMPLE_WIDTH + 10;

    // Four bits each of red, green and blue
    localparam int COLOR_WIDTH = 12;

    // Cycles from read address to read data
    localparam int READ_LATENCY = 2;

    ////////////////////////////////////////////////////////////////////////////
    // Data types
    ////////////////////////////////////////////////////////////////////////////

    typedef logic [SAMPLE_WIDTH-1:0] sample_t;

    typedef logic [ENERGY_WIDTH-1:0] energy_t;

    // Red in the top nibble, blue in the bottom one
    typedef logic [COLOR_WIDTH-1:0] color_t;

    // Accumulator FSM
    // acc_band_done is the band boundary, where the next band is picked
    typedef enum logic [1:0] {
        acc_idle,
        acc_wait_read,
        acc_accumulate,
        acc_band_done
    } acc_state_e;

endpackage

/* rtl/fft_bin_buffer.sv */
module fft_bin_buffer #(
    parameter int ADDR_WIDTH = 10
) (
    input  logic                    clock,
    input  logic                    reset,

    // Bin stream from the FFT
    input  logic                    sample_valid,
    input  spectrum_pkg::sample_t   sample_data,
    input  logic                    frame_last,

    // Frame complete strobe
    output logic                    frame_ready,

    // Read port for the accumulator
    input  logic [ADDR_WIDTH-1:0]   read_addr,
    output spectrum_pkg::sample_t   read_data
);

    import spectrum_pkg::*;

    localparam int DEPTH = 2 ** ADDR_WIDTH;

    // Bin storage, one word per FFT bin
    sample_t mem [DEPTH];

    // Next bin position in the frame
    logic [ADDR_WIDTH-1:0] write_addr;

    // Read pipeline, last stage drives read_data
    sample_t rd_pipe [READ_LATENCY];

    ////////////////////////////////////////////////////////////////////////////
    // Write side
    ////////////////////////////////////////////////////////////////////////////

    // Address counter and frame strobe
    always_ff @(posedge clock) begin
        if (reset) begin
            write_addr  <= '0;
            frame_ready <= 1'b0;
        end else begin
            // One cycle pulse after the last bin
            frame_ready <= sample_valid && frame_last;
            if (sample_valid) begin
                // Last bin wraps back to the frame start
                if (frame_last) begin
                    write_addr <= '0;
                end else begin
                    write_addr <= write_addr + 1'b1;
                end
            end
        end
    end

    // RAM write port
    always_ff @(posedge clock) begin
        if (sample_valid) begin
            mem[write_addr] <= sample_data;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Read side
    ////////////////////////////////////////////////////////////////////////////

    // Registered RAM output plus extra stages
    always_ff @(posedge clock) begin
        rd_pipe[0] <= mem[read_addr];
        for (int i = 1; i < READ_LATENCY; i++) begin
            rd_pipe[i] <= rd_pipe[i-1];
        end
    end

    assign read_data = rd_pipe[READ_LATENCY-1];

endmodule

/* rtl/band_energy_accumulator.sv */
module band_energy_accumulator #(
    parameter int ADDR_WIDTH = 10,
    parameter int NUM_BANDS  = 7
) (
    input  logic                             clock,
    input  logic                             reset,

    // Frame start from the bin buffer
    input  logic                             frame_ready,

    // Band setup, latched per frame
    input  logic [NUM_BANDS*ADDR_WIDTH-1:0]  band_edges,
    input  logic [2:0]                       active_bands,

    // Bin RAM read port
    output logic [ADDR_WIDTH-1:0]            read_addr,
    input  spectrum_pkg::sample_t            read_data,

    // Per band result
    output logic                             band_valid,
    output logic [$clog2(NUM_BANDS)-1:0]     band_index,
    output spectrum_pkg::energy_t            band_energy,

    // Frame end strobe
    output logic                             frame_done
);

    import spectrum_pkg::*;

    localparam int INDEX_WIDTH = $clog2(NUM_BANDS);
    localparam int WAIT_WIDTH  = $clog2(READ_LATENCY + 1);

    localparam logic [INDEX_WIDTH-1:0] LAST_BAND = INDEX_WIDTH'(NUM_BANDS - 1);
    localparam logic [WAIT_WIDTH-1:0]  WAIT_LAST = WAIT_WIDTH'(READ_LATENCY - 1);

    acc_state_e state;

    // Frame setup copies
    logic [NUM_BANDS*ADDR_WIDTH-1:0] edges_q;
    logic [2:0]                      active_q;

    // Band and wait counters
    logic [INDEX_WIDTH-1:0] band_cnt;
    logic [WAIT_WIDTH-1:0]  wait_cnt;

    // Running sum of the current band
    energy_t                     sum;
    energy_t                     sum_next;
    logic [2*SAMPLE_WIDTH-1:0]   square;

    // Current band limits and decisions
    logic [ADDR_WIDTH-1:0] band_end;
    logic [ADDR_WIDTH-1:0] next_addr;
    logic                  band_live;
    logic                  last_band;
    logic                  start_frame;
    logic                  band_skip;
    logic                  band_finish;

    ////////////////////////////////////////////////////////////////////////////
    // Band decode
    ////////////////////////////////////////////////////////////////////////////

    // Exclusive upper edge of the band in progress
    assign band_end  = edges_q[band_cnt*ADDR_WIDTH +: ADDR_WIDTH];
    assign next_addr = read_addr + 1'b1;

    // Active and non-empty, read_addr holds the band start here
    assign band_live = (band_cnt < active_q) && (band_end > read_addr);
    assign last_band = (band_cnt == LAST_BAND);

    assign square   = read_data * read_data;
    assign sum_next = sum + energy_t'(square);

    // FSM events
    assign start_frame = (state == acc_idle) && frame_ready;
    assign band_skip   = (state == acc_band_done) && !band_live;
    assign band_finish = (state == acc_accumulate) && (next_addr == band_end);

    ////////////////////////////////////////////////////////////////////////////
    // Control FSM
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            state      <= acc_idle;
            read_addr  <= '0;
            band_cnt   <= '0;
            wait_cnt   <= '0;
            band_valid <= 1'b0;
            frame_done <= 1'b0;
        end else begin
            band_valid <= band_skip || band_finish;
            // Frame ends one cycle after the last band report
            frame_done <= band_valid && (band_index == LAST_BAND);
            case (state)
                acc_idle: begin
                    // Busy frames never reach here, so a late frame_ready is dropped
                    if (frame_ready) begin
                        band_cnt  <= '0;
                        read_addr <= '0;
                        state     <= acc_band_done;
                    end
                end
                acc_band_done: begin
                    if (band_live) begin
                        wait_cnt <= '0;
                        state    <= acc_wait_read;
                    end else begin
                        // Empty or inactive band takes a single cycle
                        read_addr <= band_end;
                        if (last_band) begin
                            state <= acc_idle;
                        end else begin
                            band_cnt <= band_cnt + 1'b1;
                        end
                    end
                end
                acc_wait_read: begin
                    if (wait_cnt == WAIT_LAST) begin
                        state <= acc_accumulate;
                    end else begin
                        wait_cnt <= wait_cnt + 1'b1;
                    end
                end
                acc_accumulate: begin
                    read_addr <= next_addr;
                    if (next_addr == band_end) begin
                        if (last_band) begin
                            state <= acc_idle;
                        end else begin
                            band_cnt <= band_cnt + 1'b1;
                            state    <= acc_band_done;
                        end
                    end else begin
                        wait_cnt <= '0;
                        state    <= acc_wait_read;
                    end
                end
                default: state <= acc_idle;
            endcase
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (start_frame) begin
            edges_q  <= band_edges;
            active_q <= active_bands;
        end
        // Fresh sum at every band boundary
        if (state == acc_band_done) begin
            sum <= '0;
        end else if (state == acc_accumulate) begin
            sum <= sum_next;
        end
        if (band_skip) begin
            band_energy <= '0;
            band_index  <= band_cnt;
        end else if (band_finish) begin
            band_energy <= sum_next;
            band_index  <= band_cnt;
        end
    end

endmodule

/* rtl/band_color_mapper.sv */
module band_color_mapper #(
    parameter int NUM_BANDS = 7
) (
    input  logic                                         clock,
    input  logic                                         reset,

    // Band results from the accumulator
    input  logic                                         band_valid,
    input  logic [$clog2(NUM_BANDS)-1:0]                 band_index,
    input  spectrum_pkg::energy_t                        band_energy,
    input  logic                                         frame_done,

    // Packed slots, band 0 in the low bits
    output logic [NUM_BANDS*spectrum_pkg::COLOR_WIDTH-1:0] colors,
    output logic                                         colors_valid
);

    import spectrum_pkg::*;

    // Brightness level of the incoming band
    logic [3:0] level;

    // Heat color for the incoming band
    color_t heat;

    ////////////////////////////////////////////////////////////////////////////
    // Energy to level
    ////////////////////////////////////////////////////////////////////////////

    // Bits in use divided by three, roughly a log scale
    function automatic logic [3:0] energy_level(input energy_t energy);
        int unsigned width_used;
        int unsigned steps;
        width_used = 0;
        // Highest set bit wins
        for (int i = 0; i < ENERGY_WIDTH; i++) begin
            if (energy[i]) begin
                width_used = i + 1;
            end
        end
        steps = width_used / 3;
        // Cap at the top nibble value
        if (steps > 15) begin
            steps = 15;
        end
        return 4'(steps);
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Level to color
    ////////////////////////////////////////////////////////////////////////////

    always_comb begin
        level = energy_level(band_energy);
        // Red rises, green falls, a little blue at the top
        heat  = {level, 4'd15 - level, 2'b00, level[3:2]};
    end

    ////////////////////////////////////////////////////////////////////////////
    // Slot storage
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            colors       <= '0;
            colors_valid <= 1'b0;
        end else begin
            // Slots stay until the next frame rewrites them
            if (band_valid) begin
                colors[band_index*COLOR_WIDTH +: COLOR_WIDTH] <= heat;
            end
            // Last slot is written by the time frame_done arrives
            colors_valid <= frame_done;
        end
    end

endmodule

/* rtl/spectrum_visualizer.sv */
module spectrum_visualizer #(
    parameter int ADDR_WIDTH = 10,
    parameter int NUM_BANDS  = 7
) (
    input  logic                                         clock,
    input  logic                                         reset,

    // FFT bin stream
    input  logic                                         sample_valid,
    input  spectrum_pkg::sample_t                        sample_data,
    input  logic                                         frame_last,

    // Band layout
    input  logic [NUM_BANDS*ADDR_WIDTH-1:0]              band_edges,
    input  logic [2:0]                                   active_bands,

    // Heat colors
    output logic [NUM_BANDS*spectrum_pkg::COLOR_WIDTH-1:0] colors,
    output logic                                         colors_valid
);

    import spectrum_pkg::*;

    // Buffer to accumulator
    logic                  frame_ready;
    logic [ADDR_WIDTH-1:0] read_addr;
    sample_t               read_data;

    // Accumulator to mapper
    logic                         band_valid;
    logic [$clog2(NUM_BANDS)-1:0] band_index;
    energy_t                      band_energy;
    logic                         frame_done;

    ////////////////////////////////////////////////////////////////////////////
    // Input side
    ////////////////////////////////////////////////////////////////////////////

    fft_bin_buffer #(
        .ADDR_WIDTH   (ADDR_WIDTH)
    ) buffer_i (
        .clock        (clock),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .frame_last   (frame_last),
        .frame_ready  (frame_ready),
        .read_addr    (read_addr),
        .read_data    (read_data)
    );

    ////////////////////////////////////////////////////////////////////////////
    // Band sums
    ////////////////////////////////////////////////////////////////////////////

    band_energy_accumulator #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .NUM_BANDS    (NUM_BANDS)
    ) accumulator_i (
        .clock        (clock),
        .reset        (reset),
        .frame_ready  (frame_ready),
        .band_edges   (band_edges),
        .active_bands (active_bands),
        .read_addr    (read_addr),
        .read_data    (read_data),
        .band_valid   (band_valid),
        .band_index   (band_index),
        .band_energy  (band_energy),
        .frame_done   (frame_done)
    );

    // Output side
    band_color_mapper #(
        .NUM_BANDS    (NUM_BANDS)
    ) mapper_i (
        .clock        (clock),
        .reset        (reset),
        .band_valid   (band_valid),
        .band_index   (band_index),
        .band_energy  (band_energy),
        .frame_done   (frame_done),
        .colors       (colors),
        .colors_valid (colors_valid)
    );

endmodule

/* test/spectrum_visualizer_tb.sv */
module spectrum_visualizer_tb;

    import spectrum_pkg::*;

    localparam int ADDR_WIDTH      = 10;
    localparam int NUM_BANDS       = 7;
    localparam int DEPTH           = 2 ** ADDR_WIDTH;
    localparam int FRAME_TIMEOUT   = 10000;
    localparam int SETTLE_CYCLES   = 20;
    localparam int PATTERN_RANDOM  = 0;
    localparam int PATTERN_EXTREME = 1;

    logic                                clock;
    logic                                reset;
    logic                                sample_valid;
    sample_t                             sample_data;
    logic                                frame_last;
    logic [NUM_BANDS*ADDR_WIDTH-1:0]     band_edges;
    logic [2:0]                          active_bands;
    logic [NUM_BANDS*COLOR_WIDTH-1:0]    colors;
    logic                                colors_valid;

    // Mirror of the bin RAM and the current band layout
    sample_t                             mirror [DEPTH];
    int                                  edge_list [NUM_BANDS];
    logic [NUM_BANDS*ADDR_WIDTH-1:0]     layout_edges;
    logic [NUM_BANDS*COLOR_WIDTH-1:0]    expected_colors;

    // Shared between stimulus and compare process
    string       current_test = "none";
    bit          expect_frame = 1'b0;
    bit          timed_out    = 1'b0;
    int          frames_seen  = 0;
    int          mismatch_count = 0;
    int          failure_count  = 0;
    logic [31:0] lfsr_state = 32'h76eb_33c2;

    spectrum_visualizer #(
        .ADDR_WIDTH   (ADDR_WIDTH),
        .NUM_BANDS    (NUM_BANDS)
    ) dut_i (
        .clock        (clock),
        .reset        (reset),
        .sample_valid (sample_valid),
        .sample_data  (sample_data),
        .frame_last   (frame_last),
        .band_edges   (band_edges),
        .active_bands (active_bands),
        .colors       (colors),
        .colors_valid (colors_valid)
    );

    initial begin
        clock = 1'b0;
        forever #4 clock = ~clock;
    end

    ////////////////////////////////////////////////////////////////////////////
    // Random source and reference model
    ////////////////////////////////////////////////////////////////////////////

    // Galois step, taps 32 22 2 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] state);
        logic [31:0] next;
        next = state >> 1;
        if (state[0]) begin
            next = next ^ 32'h8020_0003;
        end
        return next;
    endfunction

    // One LFSR step per bit taken
    function automatic logic [31:0] take_bits(input int count);
        logic [31:0] result;
        result = '0;
        for (int i = 0; i < count; i++) begin
            result     = {result[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
        return result;
    endfunction

    function automatic sample_t pick_sample(input int pattern, input int index);
        if (pattern == PATTERN_EXTREME) begin
            // Full scale block, then silence, then noise
            if (index < 800) begin
                return 16'hFFFF;
            end else if (index < 900) begin
                return 16'h0000;
            end
        end
        return sample_t'(take_bits(16));
    endfunction

    // Expected packed colors from the mirror and a band layout
    function automatic logic [NUM_BANDS*COLOR_WIDTH-1:0] expected_frame_colors(
        input int                              active,
        input logic [NUM_BANDS*ADDR_WIDTH-1:0] edges
    );
        logic [NUM_BANDS*COLOR_WIDTH-1:0] packed_colors;
        longint unsigned                  energy;
        int                               start;
        int                               stop;
        int                               bits;
        int                               level;
        packed_colors = '0;
        start = 0;
        for (int k = 0; k < NUM_BANDS; k++) begin
            stop   = int'(edges[k*ADDR_WIDTH +: ADDR_WIDTH]);
            energy = 0;
            if (k < active && stop > start) begin
                for (int a = start; a < stop; a++) begin
                    energy += longint'(mirror[a]) * longint'(mirror[a]);
                end
            end
            // Bits in use, counted by shifting down
            bits = 0;
            while (energy != 0) begin
                bits++;
                energy = energy >> 1;
            end
            level = (bits / 3 > 15) ? 15 : bits / 3;
            packed_colors[k*COLOR_WIDTH +: COLOR_WIDTH] =
                color_t'((level << 8) | ((15 - level) << 4) | (level / 4));
            // Next band opens at this edge
            start = stop;
        end
        return packed_colors;
    endfunction

    ////////////////////////////////////////////////////////////////////////////
    // Checks
    ////////////////////////////////////////////////////////////////////////////

    task automatic check_colors(input string name, input int slot,
                                input color_t expected, input color_t actual);
        if (actual !== expected) begin
            $display("Error %s slot %0d expected %h actual %h", name, slot, expected, actual);
            mismatch_count++;
        end
    endtask

    // Compare process, one colors_valid per frame in flight
    always @(posedge clock) begin
        if (!reset && colors_valid === 1'b1) begin
            if (!expect_frame) begin
                $display("colors_valid pulsed with no frame in flight during %s", current_test);
                failure_count++;
            end else begin
                for (int s = 0; s < NUM_BANDS; s++) begin
                    check_colors(current_test, s, expected_colors[s*COLOR_WIDTH +: COLOR_WIDTH],
                                 colors[s*COLOR_WIDTH +: COLOR_WIDTH]);
                end
                expect_frame = 1'b0;
            end
            frames_seen++;
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////////////////////////////////////////

    task automatic random_edges();
        for (int k = 0; k < NUM_BANDS; k++) begin
            edge_list[k] = int'(take_bits(ADDR_WIDTH));
        end
    endtask

    // Sort, pack and drive the layout
    task automatic apply_layout(input int active);
        int value;
        int j;
        for (int i = 1; i < NUM_BANDS; i++) begin
            value = edge_list[i];
            j = i - 1;
            while (j >= 0 && edge_list[j] > value) begin
                edge_list[j+1] = edge_list[j];
                j--;
            end
            edge_list[j+1] = value;
        end
        for (int k = 0; k < NUM_BANDS; k++) begin
            layout_edges[k*ADDR_WIDTH +: ADDR_WIDTH] = ADDR_WIDTH'(edge_list[k]);
        end
        @(posedge clock);
        band_edges   <= layout_edges;
        active_bands <= 3'(active);
    endtask

    // Frames always start at address 0
    task automatic send_frame(input int length, input int pattern);
        sample_t value;
        for (int i = 0; i < length; i++) begin
            value = pick_sample(pattern, i);
            @(posedge clock);
            sample_valid <= 1'b1;
            sample_data  <= value;
            frame_last   <= (i == length - 1);
            mirror[i] = value;
        end
        @(posedge clock);
        sample_valid <= 1'b0;
        frame_last   <= 1'b0;
    endtask

    task automatic run_frame(input string name, input int length, input int pattern,
                             input int active);
        int seen_before;
        int cycles;
        current_test = name;
        apply_layout(active);
        seen_before  = frames_seen;
        expect_frame = 1'b1;
        send_frame(length, pattern);
        expected_colors = expected_frame_colors(active, layout_edges);
        cycles = 0;
        while (frames_seen == seen_before && cycles < FRAME_TIMEOUT) begin
            @(posedge clock);
            cycles++;
        end
        if (frames_seen == seen_before) begin
            $display("Timeout in %s, colors_valid never came", name);
            failure_count++;
            timed_out = 1'b1;
        end else begin
            // Quiet window, a second pulse shows up here
            repeat (SETTLE_CYCLES) @(posedge clock);
            if (frames_seen != seen_before + 1) begin
                $display("colors_valid came more than once in %s", name);
                failure_count++;
            end
        end
    endtask

    task automatic report_and_finish();
        $display("Mismatches: %0d, other failures: %0d", mismatch_count, failure_count);
        if (mismatch_count == 0 && failure_count == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    endtask

    initial begin
        reset        <= 1'b1;
        sample_valid <= 1'b0;
        sample_data  <= '0;
        frame_last   <= 1'b0;
        band_edges   <= '0;
        active_bands <= '0;
        repeat (10) @(posedge clock);
        reset <= 1'b0;

        // Idle after reset, colors cleared and no pulse
        current_test = "reset_state";
        repeat (50) @(posedge clock);
        for (int s = 0; s < NUM_BANDS; s++) begin
            check_colors(current_test, s, '0, colors[s*COLOR_WIDTH +: COLOR_WIDTH]);
        end

        // One band over the whole RAM
        edge_list = '{default: DEPTH - 1};
        run_frame("single_full_band", DEPTH, PATTERN_RANDOM, 1);

        if (!timed_out) begin
            random_edges();
            run_frame("seven_random_bands", DEPTH, PATTERN_RANDOM, NUM_BANDS);
        end
        if (!timed_out) begin
            random_edges();
            run_frame("fewer_active_bands", DEPTH, PATTERN_RANDOM, 1 + take_bits(3) % 6);
        end
        // Full scale, silent and empty bands
        if (!timed_out) begin
            edge_list = '{800, 900, 900, 900, 950, 1000, DEPTH - 1};
            run_frame("extreme_bands", DEPTH, PATTERN_EXTREME, NUM_BANDS);
        end
        // Shorter frames keep older words above their length
        if (!timed_out) begin
            random_edges();
            run_frame("long_frame", DEPTH, PATTERN_RANDOM, NUM_BANDS);
        end
        if (!timed_out) begin
            random_edges();
            run_frame("short_frame", 300, PATTERN_RANDOM, NUM_BANDS);
        end
        if (!timed_out) begin
            random_edges();
            run_frame("shortest_frame", 37, PATTERN_RANDOM, 1 + take_bits(3) % 6);
        end
        report_and_finish();
    end

endmodule

/* spectrum_visualizer.f */
rtl/spectrum_pkg.sv
rtl/fft_bin_buffer.sv
rtl/band_energy_accumulator.sv
rtl/band_color_mapper.sv
rtl/spectrum_visualizer.sv
test/spectrum_visualizer_tb.sv

/* Bender.yml */
package:
  name: spectrum_visualizer

sources:
  # Design, package first
  - files:
      - rtl/spectrum_pkg.sv
      - rtl/fft_bin_buffer.sv
      - rtl/band_energy_accumulator.sv
      - rtl/band_color_mapper.sv
      - rtl/spectrum_visualizer.sv

  # Testbench
  - target: test
    files:
      - test/spectrum_visualizer_tb.sv
